// ==== arcade_inputs.f ====
hw/input_pkg.sv
hw/ps2_key_decoder.sv
hw/player_input_merge.sv
hw/core_reset_sync.sv
hw/arcade_inputs.sv
testbench/arcade_inputs_props.sv
testbench/arcade_inputs_tb.sv

// ==== hw/arcade_inputs.sv ====
////////////////////////////////////////////////////////////
// Player input and CPU reset subsystem, clk_68k domain only
// PS/2 and joystick words must arrive already synchronous
// Joystick to player word takes 1 edge, PS/2 event takes 2
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module arcade_inputs (
  input  logic                            clk_68k,
  input  logic                            arst_n,
  input  logic [input_pkg::ps2_w-1:0]     ps2_key,
  input  logic [input_pkg::joy_w-1:0]     joystick_0,
  input  logic [input_pkg::joy_w-1:0]     joystick_1,
  input  logic                            host_reset,
  input  logic                            menu_reset,
  input  logic                            reset_button,
  input  logic                            pll_locked,
  output logic [input_pkg::player_w-1:0]  player_1,
  output logic [input_pkg::player_w-1:0]  player_2,
  output logic                            pause,
  output logic                            cpu_reset
);

  import input_pkg::*;

  // Held keys from decoder to merger
  logic [key_count-1:0] key_state;

  ////////////////////////////////////////////////////////////
  // Keyboard side
  ////////////////////////////////////////////////////////////

  ps2_key_decoder ps2_key_decoder_i (
    .clk_68k   (clk_68k),
    .arst_n    (arst_n),
    .ps2_key   (ps2_key),
    .key_state (key_state)
  );

  player_input_merge player_input_merge_i (
    .clk_68k    (clk_68k),
    .arst_n     (arst_n),
    .key_state  (key_state),
    .joystick_0 (joystick_0),
    .joystick_1 (joystick_1),
    .player_1   (player_1),
    .player_2   (player_2),
    .pause      (pause)
  );

  ////////////////////////////////////////////////////////////
  // Reset side
  ////////////////////////////////////////////////////////////

  core_reset_sync core_reset_sync_i (
    .clk_68k      (clk_68k),
    .arst_n       (arst_n),
    .host_reset   (host_reset),
    .menu_reset   (menu_reset),
    .reset_button (reset_button),
    .pll_locked   (pll_locked),
    .cpu_reset    (cpu_reset)
  );

endmodule

// ==== hw/core_reset_sync.sv ====
////////////////////////////////////////////////////////////
// CPU reset from host, menu, button and PLL lock sources
// cpu_reset follows the request by exactly sync_stages edges
// arst_n presets the chain, so the CPU starts held in reset
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module core_reset_sync (
  input  logic clk_68k,
  input  logic arst_n,
  input  logic host_reset,
  input  logic menu_reset,
  input  logic reset_button,
  input  logic pll_locked,
  output logic cpu_reset
);

  import input_pkg::*;

  // Combined request, high while any source asks for reset
  logic reset_req;

  // Synchronizer chain, stage 0 samples the request
  logic [sync_stages-1:0] sync_q;

  assign reset_req = host_reset | menu_reset | reset_button | ~pll_locked;

  always_ff @(posedge clk_68k or negedge arst_n) begin
    if (!arst_n) begin
      sync_q <= '1;
    end else begin
      sync_q <= {sync_q[sync_stages-2:0], reset_req};
    end
  end

  // Last stage drives the CPU
  assign cpu_reset = sync_q[sync_stages-1];

endmodule

// ==== hw/input_pkg.sv ====
////////////////////////////////////////////////////////////
// Shared widths, key indices and scancodes for player input
// Scancodes are PS/2 set 2 make codes without the E0 prefix
// Extended and plain codes that share a byte are not told apart
// Key count and word widths are fixed by the board
////////////////////////////////////////////////////////////

package input_pkg;

  // Word widths
  localparam int ps2_w       = 11;
  localparam int joy_w       = 10;
  localparam int player_w    = 9;
  localparam int key_count   = 19;
  localparam int sync_stages = 3;

  // Player 1 keys in the held-key vector
  localparam int key_idx_up    = 0;
  localparam int key_idx_down  = 1;
  localparam int key_idx_left  = 2;
  localparam int key_idx_right = 3;
  localparam int key_idx_ctrl  = 4;
  localparam int key_idx_alt   = 5;
  localparam int key_idx_space = 6;
  localparam int key_idx_1     = 7;
  localparam int key_idx_5     = 8;
  localparam int key_idx_p     = 9;
  // Player 2 keys
  localparam int key_idx_r     = 10;
  localparam int key_idx_f     = 11;
  localparam int key_idx_d     = 12;
  localparam int key_idx_g     = 13;
  localparam int key_idx_a     = 14;
  localparam int key_idx_s     = 15;
  localparam int key_idx_q     = 16;
  localparam int key_idx_2     = 17;
  localparam int key_idx_6     = 18;

  // Mapped scancodes, anything else is ignored by the decoder
  typedef enum logic [7:0] {
    sc_up    = 8'h75, sc_down = 8'h72, sc_left  = 8'h6B, sc_right = 8'h74,
    sc_ctrl  = 8'h14, sc_alt  = 8'h11, sc_space = 8'h29, sc_1     = 8'h16,
    sc_5     = 8'h2E, sc_p    = 8'h4D, sc_r     = 8'h2D, sc_f     = 8'h2B,
    sc_d     = 8'h23, sc_g    = 8'h34, sc_a     = 8'h1C, sc_s     = 8'h1B,
    sc_q     = 8'h15, sc_2    = 8'h1E, sc_6     = 8'h36
  } scancode_e;

endpackage

// ==== hw/player_input_merge.sv ====
////////////////////////////////////////////////////////////
// Keyboard and joystick merge into player words and pause
// Outputs are registered, one clock behind their inputs
// Player 2 has no keyboard pause key
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module player_input_merge (
  input  logic                             clk_68k,
  input  logic                             arst_n,
  input  logic [input_pkg::key_count-1:0]  key_state,
  input  logic [input_pkg::joy_w-1:0]      joystick_0,
  input  logic [input_pkg::joy_w-1:0]      joystick_1,
  output logic [input_pkg::player_w-1:0]   player_1,
  output logic [input_pkg::player_w-1:0]   player_2,
  output logic                             pause
);

  import input_pkg::*;

  // Keys gathered in player-word order, up in bit 0
  logic [player_w-1:0] p1_keys;
  logic [player_w-1:0] p2_keys;

  // Joystick order is right, left, down, up, b1..b3, start, coin
  // Player order is up, down, left, right, b1..b3, start, coin
  function automatic logic [player_w-1:0] merge_word(
    input logic [player_w-1:0] keys,
    input logic [joy_w-1:0]    joy
  );
    merge_word = keys | {joy[8:4], joy[0], joy[1], joy[2], joy[3]};
  endfunction

  assign p1_keys = {key_state[key_idx_5],     key_state[key_idx_1],
                    key_state[key_idx_space], key_state[key_idx_alt],
                    key_state[key_idx_ctrl],  key_state[key_idx_right],
                    key_state[key_idx_left],  key_state[key_idx_down],
                    key_state[key_idx_up]};

  assign p2_keys = {key_state[key_idx_6], key_state[key_idx_2],
                    key_state[key_idx_q], key_state[key_idx_s],
                    key_state[key_idx_a], key_state[key_idx_g],
                    key_state[key_idx_d], key_state[key_idx_f],
                    key_state[key_idx_r]};

  ////////////////////////////////////////////////////////////
  // Output registers
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_68k or negedge arst_n) begin
    if (!arst_n) begin
      player_1 <= '0;
      player_2 <= '0;
      pause    <= 1'b0;
    end else begin
      player_1 <= merge_word(p1_keys, joystick_0);
      player_2 <= merge_word(p2_keys, joystick_1);
      // Pause from key p or either joystick
      pause    <= key_state[key_idx_p] | joystick_0[9] | joystick_1[9];
    end
  end

endmodule

// ==== hw/ps2_key_decoder.sv ====
////////////////////////////////////////////////////////////
// PS/2 event decoder with held state per mapped key
// An event is any change of ps2_key[10] against its copy
// The toggle copy resets to 0, so a first event must carry 1
// ps2_key must already be synchronous to clk_68k
// Bit 8 of the event word is not used
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module ps2_key_decoder (
  input  logic                          clk_68k,
  input  logic                          arst_n,
  input  logic [input_pkg::ps2_w-1:0]   ps2_key,
  output logic [input_pkg::key_count-1:0] key_state
);

  import input_pkg::*;

  // Fields of the event word
  logic      toggle;
  logic      pressed;
  scancode_e code;

  // Previous toggle bit
  logic toggle_q;

  assign toggle  = ps2_key[10];
  assign pressed = ps2_key[9];
  assign code    = scancode_e'(ps2_key[7:0]);

  ////////////////////////////////////////////////////////////
  // Event detect and key tracking
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_68k or negedge arst_n) begin
    if (!arst_n) begin
      toggle_q  <= 1'b0;
      key_state <= '0;
    end else begin
      toggle_q <= toggle;
      // Key update on the same edge the toggle change is seen
      if (toggle != toggle_q) begin
        case (code)
          // Player 1
          sc_up:    key_state[key_idx_up]    <= pressed;
          sc_down:  key_state[key_idx_down]  <= pressed;
          sc_left:  key_state[key_idx_left]  <= pressed;
          sc_right: key_state[key_idx_right] <= pressed;
          sc_ctrl:  key_state[key_idx_ctrl]  <= pressed;
          sc_alt:   key_state[key_idx_alt]   <= pressed;
          sc_space: key_state[key_idx_space] <= pressed;
          sc_1:     key_state[key_idx_1]     <= pressed;
          sc_5:     key_state[key_idx_5]     <= pressed;
          sc_p:     key_state[key_idx_p]     <= pressed;
          // Player 2
          sc_r:     key_state[key_idx_r]     <= pressed;
          sc_f:     key_state[key_idx_f]     <= pressed;
          sc_d:     key_state[key_idx_d]     <= pressed;
          sc_g:     key_state[key_idx_g]     <= pressed;
          sc_a:     key_state[key_idx_a]     <= pressed;
          sc_s:     key_state[key_idx_s]     <= pressed;
          sc_q:     key_state[key_idx_q]     <= pressed;
          sc_2:     key_state[key_idx_2]     <= pressed;
          sc_6:     key_state[key_idx_6]     <= pressed;
          // Unmapped codes leave every key alone
          default: ;
        endcase
      end
    end
  end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Compile and run the arcade_inputs testbench with Verilator
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module arcade_inputs_tb \
  -f arcade_inputs.f -o arcade_inputs_sim &&
./obj_dir/arcade_inputs_sim | tee /dev/stderr | grep "Regression passed" > /dev/null &&
echo "Simulation passed" || { echo "Simulation failed"; exit 1; }

// ==== testbench/arcade_inputs_props.sv ====
////////////////////////////////////////////////////////////
// Concurrent checks on the PS/2 decoder and CPU reset chain
// Bound into arcade_inputs, which sees both blocks at once
// Toggle copy is mirrored here with reset value 0
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module arcade_inputs_props (
  input logic                            clk_68k,
  input logic                            arst_n,
  input logic [input_pkg::ps2_w-1:0]     ps2_key,
  input logic [input_pkg::key_count-1:0] key_state,
  input logic                            host_reset,
  input logic                            menu_reset,
  input logic                            reset_button,
  input logic                            pll_locked,
  input logic                            cpu_reset
);

  logic       toggle_seen;
  // Edges since reset release, saturates at 3
  logic [1:0] edges_run;
  logic       reset_req;

  assign reset_req = host_reset | menu_reset | reset_button | ~pll_locked;

  always_ff @(posedge clk_68k or negedge arst_n) begin
    if (!arst_n) begin
      toggle_seen <= 1'b0;
      edges_run   <= 2'd0;
    end else begin
      toggle_seen <= ps2_key[10];
      if (edges_run != 2'd3) begin
        edges_run <= edges_run + 2'd1;
      end
    end
  end

  // Key change needs a toggle change on the edge before
  key_change_on_event: assert property (@(posedge clk_68k) disable iff (!arst_n)
    !$stable(key_state) |-> ($past(ps2_key[10]) != $past(toggle_seen)))
    else $error("key_state changed with no PS/2 toggle");

  // Three-stage delay once the chain is filled after reset
  reset_three_edges: assert property (@(posedge clk_68k) disable iff (!arst_n)
    (edges_run == 2'd3) |-> (cpu_reset == $past(reset_req, 3)))
    else $error("cpu_reset is not the request delayed by three edges");

  reset_held_at_release: assert property (@(posedge clk_68k)
    $rose(arst_n) |-> cpu_reset)
    else $error("cpu_reset low in the first cycle after reset release");

endmodule

bind arcade_inputs arcade_inputs_props arcade_inputs_props_i (
  .clk_68k      (clk_68k),
  .arst_n       (arst_n),
  .ps2_key      (ps2_key),
  .key_state    (key_state),
  .host_reset   (host_reset),
  .menu_reset   (menu_reset),
  .reset_button (reset_button),
  .pll_locked   (pll_locked),
  .cpu_reset    (cpu_reset)
);

// ==== testbench/arcade_inputs_stim.txt ====
# ps2_key joystick_0 joystick_1 host_reset menu_reset reset_button pll_locked wait
# expected player_1 player_2 pause cpu_reset, all hex, wait in clk_68k edges
000 000 000 0 0 0 0 3 000 000 0 1
000 000 000 0 0 0 1 2 000 000 0 1
000 000 000 0 0 0 1 1 000 000 0 0
000 001 002 0 0 0 1 1 008 004 0 0
000 002 004 0 0 0 1 1 004 002 0 0
000 004 008 0 0 0 1 1 002 001 0 0
000 008 001 0 0 0 1 1 001 008 0 0
000 0A0 150 0 0 0 1 1 0A0 150 0 0
000 200 000 0 0 0 1 1 000 000 1 0
000 000 200 0 0 0 1 1 000 000 1 0
675 000 000 0 0 0 1 1 000 000 0 0
675 000 000 0 0 0 1 1 001 000 0 0
675 000 000 0 0 0 1 2 001 000 0 0
075 000 000 0 0 0 1 2 000 000 0 0
672 000 000 0 0 0 1 2 002 000 0 0
26B 000 000 0 0 0 1 2 006 000 0 0
674 000 000 0 0 0 1 2 00E 000 0 0
214 000 000 0 0 0 1 2 01E 000 0 0
611 000 000 0 0 0 1 2 03E 000 0 0
229 000 000 0 0 0 1 2 07E 000 0 0
616 000 000 0 0 0 1 2 0FE 000 0 0
22E 000 000 0 0 0 1 2 1FE 000 0 0
64D 000 000 0 0 0 1 2 1FE 000 1 0
22D 000 000 0 0 0 1 2 1FE 001 1 0
62B 000 000 0 0 0 1 2 1FE 003 1 0
223 000 000 0 0 0 1 2 1FE 007 1 0
634 000 000 0 0 0 1 2 1FE 00F 1 0
21C 000 000 0 0 0 1 2 1FE 01F 1 0
61B 000 000 0 0 0 1 2 1FE 03F 1 0
215 000 000 0 0 0 1 2 1FE 07F 1 0
61E 000 000 0 0 0 1 2 1FE 0FF 1 0
236 000 000 0 0 0 1 2 1FE 1FF 1 0
65A 000 000 0 0 0 1 2 1FE 1FF 1 0
245 000 000 0 0 0 1 2 1FE 1FF 1 0
44D 000 000 0 0 0 1 2 1FE 1FF 0 0
014 000 000 0 0 0 1 2 1EE 1FF 0 0
42D 000 000 0 0 0 1 2 1EE 1FE 0 0
42D 008 000 0 0 0 1 1 1EF 1FE 0 0
42D 018 000 0 0 0 1 1 1FF 1FE 0 0
02E 118 000 0 0 0 1 2 1FF 1FE 0 0
02E 018 000 0 0 0 1 1 0FF 1FE 0 0
02E 018 000 1 0 0 1 2 0FF 1FE 0 0
02E 018 000 1 0 0 1 1 0FF 1FE 0 1
02E 018 000 0 0 0 1 2 0FF 1FE 0 1
02E 018 000 0 0 0 1 1 0FF 1FE 0 0
02E 018 000 0 1 0 1 3 0FF 1FE 0 1
02E 018 000 0 0 0 1 3 0FF 1FE 0 0
02E 018 000 0 0 1 1 3 0FF 1FE 0 1
02E 018 000 0 0 0 1 3 0FF 1FE 0 0
02E 018 000 0 0 0 0 3 0FF 1FE 0 1
02E 018 000 0 0 0 1 3 0FF 1FE 0 0

// ==== testbench/arcade_inputs_tb.sv ====
////////////////////////////////////////////////////////////
// Testbench for arcade_inputs, driven by a stimulus file
// Each file line gives inputs, a wait in edges and outputs
// Inputs change 2 ns after a rising edge, outputs are read
// 1 ns after the last edge of the wait
// The first PS/2 event after reset must carry toggle 1
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module arcade_inputs_tb;

  import input_pkg::*;

  logic                clk_68k = 1'b0;
  logic                arst_n;
  logic [ps2_w-1:0]    ps2_key;
  logic [joy_w-1:0]    joystick_0;
  logic [joy_w-1:0]    joystick_1;
  logic                host_reset;
  logic                menu_reset;
  logic                reset_button;
  logic                pll_locked;
  logic [player_w-1:0] player_1;
  logic [player_w-1:0] player_2;
  logic                pause;
  logic                cpu_reset;

  // Stimulus columns, one entry per file line
  logic [ps2_w-1:0]    stim_ps2[$];
  logic [joy_w-1:0]    stim_joy0[$];
  logic [joy_w-1:0]    stim_joy1[$];
  logic [3:0]          stim_resets[$];
  int                  stim_wait[$];
  logic [player_w-1:0] stim_p1[$];
  logic [player_w-1:0] stim_p2[$];
  logic [1:0]          stim_levels[$];
  bit                  stim_loaded = 1'b0;
  int                  step;

  // Reference model state
  logic                 model_toggle;
  // Player 1 word bits, then key p, then player 2 word bits
  logic [key_count-1:0] model_keys;
  logic [player_w-1:0]  model_p1;
  logic [player_w-1:0]  model_p2;
  logic                 model_pause;
  logic [2:0]           model_chain;

  always #20 clk_68k = ~clk_68k;

  arcade_inputs arcade_inputs_i (.*);

  // Model slot of a scancode, zero when unmapped
  function automatic logic [key_count-1:0] key_mask(input logic [7:0] code);
    case (code)
      8'h75: key_mask = 19'd1 << 0;
      8'h72: key_mask = 19'd1 << 1;
      8'h6B: key_mask = 19'd1 << 2;
      8'h74: key_mask = 19'd1 << 3;
      8'h14: key_mask = 19'd1 << 4;
      8'h11: key_mask = 19'd1 << 5;
      8'h29: key_mask = 19'd1 << 6;
      8'h16: key_mask = 19'd1 << 7;
      8'h2E: key_mask = 19'd1 << 8;
      8'h4D: key_mask = 19'd1 << 9;
      8'h2D: key_mask = 19'd1 << 10;
      8'h2B: key_mask = 19'd1 << 11;
      8'h23: key_mask = 19'd1 << 12;
      8'h34: key_mask = 19'd1 << 13;
      8'h1C: key_mask = 19'd1 << 14;
      8'h1B: key_mask = 19'd1 << 15;
      8'h15: key_mask = 19'd1 << 16;
      8'h1E: key_mask = 19'd1 << 17;
      8'h36: key_mask = 19'd1 << 18;
      default: key_mask = '0;
    endcase
  endfunction

  // Joystick order into player-word order
  function automatic logic [player_w-1:0] joy_to_player(input logic [joy_w-1:0] joy);
    logic [player_w-1:0] word;
    word[0]   = joy[3];
    word[1]   = joy[2];
    word[2]   = joy[1];
    word[3]   = joy[0];
    word[8:4] = joy[8:4];
    return word;
  endfunction

  // One clock edge of the model
  task automatic advance_model();
    logic [key_count-1:0] mask;
    // Registered outputs see the keys held before this edge
    model_p1    = model_keys[8:0] | joy_to_player(joystick_0);
    model_p2    = model_keys[18:10] | joy_to_player(joystick_1);
    model_pause = model_keys[9] | joystick_0[9] | joystick_1[9];
    model_chain = {model_chain[1:0], host_reset | menu_reset | reset_button | ~pll_locked};
    if (ps2_key[10] != model_toggle) begin
      mask       = key_mask(ps2_key[7:0]);
      model_keys = ps2_key[9] ? (model_keys | mask) : (model_keys & ~mask);
    end
    model_toggle = ps2_key[10];
  endtask

  task automatic check_value(input string name, input logic [15:0] expected,
                             input logic [15:0] actual);
    assert (actual == expected) else begin
      $display("error: %s expected %h actual %h at step %0d", name, expected, actual, step);
      $display("Regression failed");
      $fatal(1, "Output check failed");
    end
  endtask

  task automatic load_stimulus();
    int    fd;
    int    rc;
    string line;
    int    f[12];
    fd = $fopen("testbench/arcade_inputs_stim.txt", "r");
    if (fd == 0) begin
      $display("The stimulus file could not be opened");
      $display("Regression failed");
      $fatal(1, "No stimulus");
    end
    while (!$feof(fd)) begin
      rc = $fgets(line, fd);
      // Skip comments and blank lines
      if (rc == 0 || line.len() < 2 || line[0] == "#") continue;
      rc = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h", f[0], f[1], f[2],
                   f[3], f[4], f[5], f[6], f[7], f[8], f[9], f[10], f[11]);
      if (rc != 12 || f[7] < 1) begin
        $display("A stimulus line is malformed: %s", line);
        $display("Regression failed");
        $fatal(1, "Bad stimulus");
      end
      stim_ps2.push_back(f[0][10:0]);
      stim_joy0.push_back(f[1][9:0]);
      stim_joy1.push_back(f[2][9:0]);
      stim_resets.push_back({f[3][0], f[4][0], f[5][0], f[6][0]});
      stim_wait.push_back(f[7]);
      stim_p1.push_back(f[8][8:0]);
      stim_p2.push_back(f[9][8:0]);
      stim_levels.push_back({f[10][0], f[11][0]});
    end
    $fclose(fd);
  endtask

  task automatic run_step(input int i);
    logic [31:0] rnd;
    rnd        = $urandom();
    step       = i;
    ps2_key    = stim_ps2[i];
    // Unused bit, the decoder must ignore it
    ps2_key[8] = rnd[0];
    // Repeated toggles and unmapped codes get the opposite pressed flag
    if (ps2_key[10] == model_toggle || key_mask(ps2_key[7:0]) == '0) begin
      ps2_key[9] = ~ps2_key[9];
    end
    joystick_0 = stim_joy0[i];
    joystick_1 = stim_joy1[i];
    {host_reset, menu_reset, reset_button, pll_locked} = stim_resets[i];
    repeat (stim_wait[i]) begin
      @(posedge clk_68k);
      advance_model();
    end
    #1;
    // File against model, then DUT against file
    check_value("model player_1", 16'(stim_p1[i]), 16'(model_p1));
    check_value("model player_2", 16'(stim_p2[i]), 16'(model_p2));
    check_value("model pause", 16'(stim_levels[i][1]), 16'(model_pause));
    check_value("model cpu_reset", 16'(stim_levels[i][0]), 16'(model_chain[2]));
    check_value("player_1", 16'(stim_p1[i]), 16'(player_1));
    check_value("player_2", 16'(stim_p2[i]), 16'(player_2));
    check_value("pause", 16'(stim_levels[i][1]), 16'(pause));
    check_value("cpu_reset", 16'(stim_levels[i][0]), 16'(cpu_reset));
    #1;
  endtask

  ////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////

  initial begin
    void'($urandom(32'h243e0353));
    arst_n       = 1'b0;
    ps2_key      = '0;
    joystick_0   = '0;
    joystick_1   = '0;
    host_reset   = 1'b0;
    menu_reset   = 1'b0;
    reset_button = 1'b0;
    pll_locked   = 1'b0;
    // Model matches the DUT reset state
    model_toggle = 1'b0;
    model_keys   = '0;
    model_p1     = '0;
    model_p2     = '0;
    model_pause  = 1'b0;
    model_chain  = 3'b111;
    load_stimulus();
    stim_loaded = 1'b1;
    repeat (3) @(posedge clk_68k);
    #2;
    arst_n = 1'b1;
    foreach (stim_ps2[i]) run_step(i);
    $display("Regression passed");
    $finish;
  end

  // Watchdog, 8 edges per line plus margin
  initial begin
    longint limit_ns;
    wait (stim_loaded);
    limit_ns = (longint'(stim_ps2.size()) * 8 + 20) * 40;
    #(limit_ns);
    $display("Simulation timed out");
    $display("Regression failed");
    $fatal(1, "Watchdog expired");
  end

endmodule
